/* Makefile */
# Verilator flow for the MAROC data-collection core

VERILATOR ?= verilator
TOP       ?= tb_maroc_dc
RTL_TOP   ?= maroc_dc_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || \
		(echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/maroc_chan_pkg.sv */
`default_nettype none

package maroc_chan_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel and trigger geometry
  //////////////////////////////////////////////////////////////////////
  localparam int NUM_CHANNELS = 16;
  localparam int CHAN_IDX_W   = 4;
  localparam int EXT_BIT      = NUM_CHANNELS;      // Ext trigger after the channels
  localparam int SW_BIT       = NUM_CHANNELS + 1;  // Software trigger on top
  localparam int TRIG_IN_W    = NUM_CHANNELS + 2;
  localparam int MASK_W       = NUM_CHANNELS + 1;

  // Counter and timing widths
  localparam int COUNT_W       = 16;  // Image counters saturate at all ones
  localparam int ET_W          = 28;
  localparam int FRAME_INT_W   = 8;
  localparam int FRAME_TICK    = 256;
  localparam int FRAME_TIMER_W = FRAME_INT_W + $clog2(FRAME_TICK);
  localparam int DELAY_W       = 4;

  // Bits of mode_e
  localparam int PH_BIT  = 0;
  localparam int IMG_BIT = 1;

  typedef enum logic [1:0] {
    MODE_NONE  = 2'b00,
    MODE_PH    = 2'b01,
    MODE_IMAGE = 2'b10,
    MODE_BOTH  = 2'b11
  } mode_e;

  // Run configuration, static while a run is active
  typedef struct packed {
    logic [MASK_W-1:0]      mask;            // High bit disables that trigger
    logic [FRAME_INT_W-1:0] frame_interval;  // In units of FRAME_TICK cycles
    logic [DELAY_W-1:0]     hold1_delay;
    logic [DELAY_W-1:0]     hold2_delay;
    mode_e                  mode;
  } daq_cfg_t;

endpackage

`default_nettype wire

/* common/readout_pkg.sv */
`default_nettype none

package readout_pkg;

  localparam int DATA_W      = 32;
  localparam int TAG_W       = 4;
  localparam int IDX_FIELD_W = 12;  // Channel index field of an image word

  // Word type in the top nibble of every data word
  typedef enum logic [TAG_W-1:0] {
    TAG_IMAGE   = 4'd1,
    TAG_PH_TIME = 4'd2
  } word_tag_e;

  // One stream beat, qualified by a separate tvalid
  //   Image word   tag[31:28] channel[27:16] count[15:0]
  //   PH time word tag[31:28] elapsed_time[27:0]
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } stream_beat_t;

  typedef enum logic [1:0] {
    IMG_COUNT,
    IMG_READ,
    IMG_CLEAR
  } img_state_e;

  typedef enum logic {
    PH_IDLE,
    PH_SEND
  } ph_state_e;

endpackage

`default_nettype wire

/* hdl/maroc_dc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module maroc_dc_top import maroc_chan_pkg::*; import readout_pkg::*; (
  input  wire logic                    axi_clk,
  input  wire logic                    reset_hold_ET0,
  input  wire logic [NUM_CHANNELS-1:0] chan_trig,
  input  wire logic                    ext_trig,
  input  wire logic                    sw_trig,
  input  wire logic [ET_W-1:0]         elapsed_time,
  input  wire daq_cfg_t                cfg,
  // Image stream
  output stream_beat_t                 image_beat,
  output logic                         image_tvalid,
  input  wire logic                    image_tready,
  // Pulse-height stream
  output stream_beat_t                 ph_beat,
  output logic                         ph_tvalid,
  input  wire logic                    ph_tready,
  // MAROC holds, active high
  output logic                         hold1,
  output logic                         hold2
);

  logic [NUM_CHANNELS-1:0] chan_pulse;
  logic                    ph_trig;
  logic                    count_freeze;
  logic                    count_clear;
  logic [CHAN_IDX_W-1:0]   rd_sel;
  logic [COUNT_W-1:0]      rd_count;
  logic                    ph_release;

  //////////////////////////////////////////////////////////////////////
  // Trigger intake and image path
  //////////////////////////////////////////////////////////////////////
  trig_front trig_front0 (
    .axi_clk, .reset_hold_ET0, .chan_trig, .ext_trig, .sw_trig, .cfg,
    .chan_pulse, .ph_trig
  );

  chan_counters chan_counters0 (
    .axi_clk, .reset_hold_ET0, .chan_pulse, .count_freeze, .count_clear,
    .rd_sel, .rd_count
  );

  image_readout image_readout0 (
    .axi_clk, .reset_hold_ET0, .cfg, .rd_count, .image_tready,
    .count_freeze, .count_clear, .rd_sel, .image_beat, .image_tvalid
  );

  //////////////////////////////////////////////////////////////////////
  // Pulse-height path
  //////////////////////////////////////////////////////////////////////
  hold_gen hold1_gen (
    .axi_clk, .reset_hold_ET0, .ph_trig, .hold_delay(cfg.hold1_delay),
    .ph_release, .hold(hold1)
  );

  hold_gen hold2_gen (
    .axi_clk, .reset_hold_ET0, .ph_trig, .hold_delay(cfg.hold2_delay),
    .ph_release, .hold(hold2)
  );

  ph_event ph_event0 (
    .axi_clk, .reset_hold_ET0, .ph_trig, .elapsed_time, .ph_tready,
    .ph_beat, .ph_tvalid, .ph_release
  );

endmodule

`default_nettype wire

/* image/chan_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module chan_counters import maroc_chan_pkg::*; (
  input  wire logic                    axi_clk,
  input  wire logic                    reset_hold_ET0,
  input  wire logic [NUM_CHANNELS-1:0] chan_pulse,
  input  wire logic                    count_freeze,
  input  wire logic                    count_clear,
  input  wire logic [CHAN_IDX_W-1:0]   rd_sel,
  output logic      [COUNT_W-1:0]      rd_count
);

  logic [NUM_CHANNELS-1:0][COUNT_W-1:0] count_q;

  //////////////////////////////////////////////////////////////////////
  // Per-channel edge counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge axi_clk) begin
    if (reset_hold_ET0 || count_clear) begin
      count_q <= '0;
    end else if (!count_freeze) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        // Stick at full scale rather than wrap
        if (chan_pulse[i] && (count_q[i] != {COUNT_W{1'b1}})) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  // Registered read mux, data one cycle after rd_sel
  always_ff @(posedge axi_clk) begin
    rd_count <= count_q[rd_sel];
  end

  // Frozen image stays put while the sequencer reads it out
  a_freeze_stable: assert property (@(posedge axi_clk) disable iff (reset_hold_ET0)
    (count_freeze && !count_clear) |=> $stable(count_q));

endmodule

`default_nettype wire

/* image/image_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module image_readout import maroc_chan_pkg::*; import readout_pkg::*; (
  input  wire logic                  axi_clk,
  input  wire logic                  reset_hold_ET0,
  input  wire daq_cfg_t              cfg,
  input  wire logic [COUNT_W-1:0]    rd_count,
  input  wire logic                  image_tready,
  output logic                       count_freeze,
  output logic                       count_clear,
  output logic      [CHAN_IDX_W-1:0] rd_sel,
  output stream_beat_t               image_beat,
  output logic                       image_tvalid
);

  img_state_e               state;
  logic [FRAME_TIMER_W-1:0] frame_timer;
  logic [FRAME_TIMER_W-1:0] frame_len;
  logic                     img_on;
  logic                     rd_wait;  // Read mux settling
  logic                     last_chan;
  logic                     xfer;

  assign img_on    = cfg.mode[IMG_BIT];
  assign frame_len = FRAME_TIMER_W'(cfg.frame_interval) * FRAME_TIMER_W'(FRAME_TICK);
  assign last_chan = (rd_sel == CHAN_IDX_W'(NUM_CHANNELS - 1));
  assign xfer      = image_tvalid && image_tready;

  // Counters stay cleared while image mode is off
  assign count_clear  = (state == IMG_CLEAR) || ((state == IMG_COUNT) && !img_on);
  assign count_freeze = (state == IMG_READ);

  always_comb begin
    image_beat.data = {TAG_IMAGE, IDX_FIELD_W'(rd_sel), rd_count};
    image_beat.last = last_chan;
  end

  //////////////////////////////////////////////////////////////////////
  // Frame timer and readout sequencer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge axi_clk) begin
    if (reset_hold_ET0) begin
      state        <= IMG_COUNT;
      frame_timer  <= '0;
      rd_sel       <= '0;
      rd_wait      <= 1'b0;
      image_tvalid <= 1'b0;
    end else begin
      case (state)
        IMG_COUNT: begin
          if (!img_on) begin
            frame_timer <= '0;
          end else if ((frame_timer + 1'b1) >= frame_len) begin
            frame_timer <= '0;
            state       <= IMG_READ;
            rd_sel      <= '0;
            rd_wait     <= 1'b1;
          end else begin
            frame_timer <= frame_timer + 1'b1;
          end
        end
        IMG_READ: begin
          if (rd_wait) begin
            rd_wait      <= 1'b0;
            image_tvalid <= 1'b1;  // rd_count lands on this edge
          end else if (xfer) begin
            image_tvalid <= 1'b0;
            if (last_chan) begin
              state <= IMG_CLEAR;
            end else begin
              rd_sel  <= rd_sel + 1'b1;
              rd_wait <= 1'b1;
            end
          end
        end
        IMG_CLEAR: begin
          state <= IMG_COUNT;  // Single clear cycle
        end
        default: begin
          state <= IMG_COUNT;
        end
      endcase
    end
  end

  // Stalled beat holds until the sink takes it
  a_beat_stable: assert property (@(posedge axi_clk) disable iff (reset_hold_ET0)
    (image_tvalid && !image_tready) |=> (image_tvalid && $stable(image_beat)));

endmodule

`default_nettype wire

/* pulseheight/hold_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module hold_gen import maroc_chan_pkg::*; (
  input  wire logic               axi_clk,
  input  wire logic               reset_hold_ET0,
  input  wire logic               ph_trig,
  input  wire logic [DELAY_W-1:0] hold_delay,
  input  wire logic               ph_release,
  output logic                    hold
);

  logic               armed;
  logic               held;
  logic [DELAY_W-1:0] delay_cnt;

  assign hold = held;

  always_ff @(posedge axi_clk) begin
    if (reset_hold_ET0) begin
      armed     <= 1'b0;
      held      <= 1'b0;
      delay_cnt <= '0;
    end else if (ph_release) begin
      armed <= 1'b0;  // Event gone, drop a pending hold too
      held  <= 1'b0;
    end else if (ph_trig && !armed && !held) begin
      if (hold_delay == '0) begin
        held <= 1'b1;
      end else begin
        armed     <= 1'b1;
        delay_cnt <= hold_delay;
      end
    end else if (armed) begin
      if (delay_cnt == DELAY_W'(1)) begin
        armed <= 1'b0;
        held  <= 1'b1;
      end else begin
        delay_cnt <= delay_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* pulseheight/ph_event.sv */
`timescale 1ns/1ps
`default_nettype none

module ph_event import maroc_chan_pkg::*; import readout_pkg::*; (
  input  wire logic            axi_clk,
  input  wire logic            reset_hold_ET0,
  input  wire logic            ph_trig,
  input  wire logic [ET_W-1:0] elapsed_time,
  input  wire logic            ph_tready,
  output stream_beat_t         ph_beat,
  output logic                 ph_tvalid,
  output logic                 ph_release
);

  ph_state_e       state;
  logic [ET_W-1:0] et_held;  // Time stamp of the pending event

  assign ph_tvalid  = (state == PH_SEND);
  assign ph_release = ph_tvalid && ph_tready;  // Pulse on the transfer cycle

  // One-word event, always the last of its packet
  always_comb begin
    ph_beat.data = {TAG_PH_TIME, et_held};
    ph_beat.last = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Event state machine
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge axi_clk) begin
    if (reset_hold_ET0) begin
      state <= PH_IDLE;
    end else begin
      case (state)
        PH_IDLE: begin
          if (ph_trig) begin
            state <= PH_SEND;
          end
        end
        PH_SEND: begin
          // New triggers are dropped until the word leaves
          if (ph_tready) begin
            state <= PH_IDLE;
          end
        end
        default: begin
          state <= PH_IDLE;
        end
      endcase
    end
  end

  // Capture on the accepted trigger only
  always_ff @(posedge axi_clk) begin
    if ((state == PH_IDLE) && ph_trig) begin
      et_held <= elapsed_time;
    end
  end

  a_ph_stable: assert property (@(posedge axi_clk) disable iff (reset_hold_ET0)
    (ph_tvalid && !ph_tready) |=> (ph_tvalid && $stable(ph_beat)));

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
common/maroc_chan_pkg.sv
common/readout_pkg.sv
trigger/trig_front.sv
image/chan_counters.sv
image/image_readout.sv
pulseheight/hold_gen.sv
pulseheight/ph_event.sv
hdl/maroc_dc_top.sv
tb/tb_maroc_dc.sv

/* tb/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

  logic [31:0] lcg_state = 32'hb827;
  int          exp_count [NUM_CHANNELS];  // Expected image counter per channel
  int          err_cnt;
  int          test_err;
  int          check_cnt;

  // Numerical Recipes LCG
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next() >> 8;  // Low bits repeat too soon
    return int'(r % 32'(n));
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      err_cnt++;
      test_err++;
      $display("** Error: %s expected %h actual %h", test_name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////
  function automatic void clear_model();
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      exp_count[i] = 0;
    end
  endfunction

  function automatic void count_edge(input int chan);
    if (exp_count[chan] < (1 << COUNT_W) - 1) begin  // Saturate at full scale
      exp_count[chan]++;
    end
  endfunction

  function automatic logic [31:0] image_word(input int chan, input int count);
    logic [31:0] w;
    w[31:28] = TAG_IMAGE;
    w[27:16] = 12'(chan);
    w[15:0]  = 16'(count);
    return w;
  endfunction

  function automatic logic [31:0] ph_word(input logic [ET_W-1:0] et);
    logic [31:0] w;
    w[31:28] = TAG_PH_TIME;
    w[27:0]  = et;
    return w;
  endfunction

`endif

/* tb/tb_maroc_dc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_maroc_dc import maroc_chan_pkg::*; import readout_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int FRAME_INT    = 4;
  localparam int FRAME_CYCLES = FRAME_INT * FRAME_TICK;
  localparam int EDGE_WINDOW  = 600;
  localparam int PH_TRIALS    = 10;
  // Four frames with stalls, two edge windows, PH trials, holds, then margin
  localparam int RUN_CYCLES = 8 * FRAME_CYCLES + 2 * EDGE_WINDOW + PH_TRIALS * 80 + 400;

  logic                    axi_clk;
  logic                    reset_hold_ET0;
  logic [NUM_CHANNELS-1:0] chan_trig;
  logic                    ext_trig;
  logic                    sw_trig;
  logic [ET_W-1:0]         elapsed_time;
  daq_cfg_t                cfg;
  stream_beat_t            image_beat;
  logic                    image_tvalid;
  logic                    image_tready;
  stream_beat_t            ph_beat;
  logic                    ph_tvalid;
  logic                    ph_tready;
  logic                    hold1;
  logic                    hold2;

  `include "tb_util.svh"

  maroc_dc_top dut0 (
    .axi_clk, .reset_hold_ET0, .chan_trig, .ext_trig, .sw_trig, .elapsed_time, .cfg,
    .image_beat, .image_tvalid, .image_tready, .ph_beat, .ph_tvalid, .ph_tready,
    .hold1, .hold2
  );

  initial begin
    axi_clk = 1'b0;
    forever #(CLK_PERIOD / 2) axi_clk = ~axi_clk;
  end

  // Just past the rising edge, where inputs change and outputs have settled
  task automatic step();
    @(posedge axi_clk);
    #1;
  endtask

  task automatic report_test(input string test_name);
    if (test_err == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, test_err);
    end
    test_err = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Image mode
  ////////////////////////////////////////////////////////////////////////
  task automatic drive_edges();
    int cyc;
    int n_edges;
    int chan;
    int hi;
    int lo;
    cyc     = 0;
    n_edges = 20 + rand_below(60);
    for (int k = 0; k < n_edges && cyc < EDGE_WINDOW - 10; k++) begin
      chan = rand_below(NUM_CHANNELS);
      hi   = 2 + rand_below(3);
      lo   = 2 + rand_below(4);
      chan_trig[chan] = 1'b1;
      count_edge(chan);
      repeat (hi) step();
      chan_trig[chan] = 1'b0;
      repeat (lo) step();
      cyc += hi + lo;
    end
  endtask

  task automatic collect_frame(input string test_name, input bit stall);
    int           idx;
    int           cyc;
    bit           held;  // Beat was stalled last cycle
    stream_beat_t held_beat;
    idx  = 0;
    cyc  = 0;
    held = 1'b0;
    while (idx < NUM_CHANNELS && cyc < 2 * FRAME_CYCLES) begin
      image_tready = stall ? (rand_below(4) != 0) : 1'b1;
      if (held) begin
        check_value({test_name, " stalled tvalid"}, 32'd1, 32'(image_tvalid));
        check_value({test_name, " stalled data"}, held_beat.data, image_beat.data);
        check_value({test_name, " stalled last"}, 32'(held_beat.last), 32'(image_beat.last));
      end
      held      = image_tvalid && !image_tready;
      held_beat = image_beat;
      if (image_tvalid && image_tready) begin
        check_value(test_name, image_word(idx, exp_count[idx]), image_beat.data);
        check_value({test_name, " last"}, 32'(idx == NUM_CHANNELS - 1), 32'(image_beat.last));
        idx++;
      end
      step();
      cyc++;
    end
    image_tready = 1'b0;
    if (idx < NUM_CHANNELS) begin
      err_cnt++;
      test_err++;
      $display("%s: image frame stopped after %0d of %0d words", test_name, idx,
               NUM_CHANNELS);
    end
  endtask

  task automatic test_image(input string test_name, input bit stall);
    clear_model();
    cfg.mask = MASK_W'(lcg_next());  // Counts ignore the mask
    cfg.mode = MODE_IMAGE;
    drive_edges();
    collect_frame(test_name, stall);
    clear_model();                   // Quiet frame reads back zeros
    collect_frame(test_name, stall);
    cfg.mode = MODE_NONE;
    step();
    report_test(test_name);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Pulse-height mode
  ////////////////////////////////////////////////////////////////////////
  task automatic test_ph_event();
    int              src;
    int              words;
    bit              expect_word;
    logic [ET_W-1:0] et;
    cfg.mode  = MODE_PH;
    cfg.mask  = MASK_W'(lcg_next());
    ph_tready = 1'b1;
    for (int t = 0; t < PH_TRIALS; t++) begin
      src = (t == 0) ? SW_BIT : (t == 1) ? EXT_BIT : rand_below(NUM_CHANNELS + 2);
      et  = ET_W'(lcg_next());
      elapsed_time = et;
      if (src == SW_BIT) begin
        expect_word = 1'b1;
        sw_trig     = 1'b1;
      end else begin
        expect_word = !cfg.mask[src];
        if (src == EXT_BIT) begin
          ext_trig = 1'b1;
        end else begin
          chan_trig[src] = 1'b1;
        end
      end
      words = 0;
      for (int k = 0; k < 50; k++) begin
        if (k == 3) begin
          chan_trig = '0;
          ext_trig  = 1'b0;
          sw_trig   = 1'b0;
        end
        if (ph_tvalid && ph_tready) begin
          words++;
          check_value("ph_event data", ph_word(et), ph_beat.data);
          check_value("ph_event last", 32'd1, 32'(ph_beat.last));
        end
        step();
      end
      check_value("ph_event word count", 32'(expect_word), 32'(words));
    end
    report_test("ph_event");
  endtask

  task automatic test_holds();
    int chan;
    int words;
    chan = rand_below(NUM_CHANNELS);
    cfg.mode        = MODE_PH;
    cfg.mask        = MASK_W'(lcg_next()) & ~(MASK_W'(1) << chan);
    cfg.hold1_delay = DELAY_W'(rand_below(16));
    cfg.hold2_delay = DELAY_W'(rand_below(16));
    elapsed_time    = ET_W'(lcg_next());
    ph_tready       = 1'b0;
    words           = 0;
    chan_trig[chan] = 1'b1;
    for (int k = 0; k < 100; k++) begin
      if (k == 5) begin
        chan_trig[chan] = 1'b0;
      end
      sw_trig = (k >= 25 && k < 28);  // Retrigger inside the stall
      if (k == 40) begin
        ph_tready = 1'b1;
      end
      if (k >= 20 && k <= 40) begin
        check_value("holds hold1 high", 32'd1, 32'(hold1));
        check_value("holds hold2 high", 32'd1, 32'(hold2));
      end else if (k >= 42) begin
        check_value("holds hold1 low", 32'd0, 32'(hold1));
        check_value("holds hold2 low", 32'd0, 32'(hold2));
      end
      if (ph_tvalid && ph_tready) begin
        words++;
        check_value("holds data", ph_word(elapsed_time), ph_beat.data);
      end
      step();
    end
    check_value("holds word count", 32'd1, 32'(words));
    cfg.mode = MODE_NONE;
    report_test("holds");
  endtask

  initial begin
    reset_hold_ET0 = 1'b1;
    chan_trig      = '0;
    ext_trig       = 1'b0;
    sw_trig        = 1'b0;
    elapsed_time   = '0;
    image_tready   = 1'b0;
    ph_tready      = 1'b0;
    cfg            = '0;
    cfg.mode       = MODE_NONE;
    cfg.frame_interval = FRAME_INT_W'(FRAME_INT);
    err_cnt   = 0;
    test_err  = 0;
    check_cnt = 0;
    repeat (5) step();
    reset_hold_ET0 = 1'b0;
    step();
    check_value("reset image_tvalid", 32'd0, 32'(image_tvalid));
    check_value("reset ph_tvalid", 32'd0, 32'(ph_tvalid));
    check_value("reset hold1", 32'd0, 32'(hold1));
    check_value("reset hold2", 32'd0, 32'(hold2));
    report_test("reset_state");
    test_image("image_counts", 1'b0);
    test_image("image_backpressure", 1'b1);
    test_ph_event();
    test_holds();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (RUN_CYCLES) @(posedge axi_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", RUN_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* trigger/trig_front.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_front import maroc_chan_pkg::*; (
  input  wire logic                    axi_clk,
  input  wire logic                    reset_hold_ET0,
  input  wire logic [NUM_CHANNELS-1:0] chan_trig,
  input  wire logic                    ext_trig,
  input  wire logic                    sw_trig,
  input  wire daq_cfg_t                cfg,
  output logic      [NUM_CHANNELS-1:0] chan_pulse,
  output logic                         ph_trig
);

  logic [TRIG_IN_W-1:0]    in_raw;
  logic [TRIG_IN_W-1:0]    in_s1;
  logic [TRIG_IN_W-1:0]    in_s2;
  logic [NUM_CHANNELS-1:0] chan_d;  // Edge history for the counters
  logic                    sw_d;
  logic                    hw_lvl;
  logic                    hw_lvl_d;
  logic                    hw_edge;
  logic                    sw_edge;

  assign in_raw = {sw_trig, ext_trig, chan_trig};

  // Masked channels and ext ORed, only in PH mode
  assign hw_lvl  = (|(in_s2[EXT_BIT:0] & ~cfg.mask)) & cfg.mode[PH_BIT];
  assign hw_edge = hw_lvl & ~hw_lvl_d;
  assign sw_edge = in_s2[SW_BIT] & ~sw_d & cfg.mode[PH_BIT];

  always_ff @(posedge axi_clk) begin
    if (reset_hold_ET0) begin
      in_s1      <= '0;
      in_s2      <= '0;
      chan_d     <= '0;
      sw_d       <= 1'b0;
      hw_lvl_d   <= 1'b0;
      chan_pulse <= '0;
      ph_trig    <= 1'b0;
    end else begin
      in_s1    <= in_raw;  // Async inputs, two-flop sync
      in_s2    <= in_s1;
      chan_d   <= in_s2[NUM_CHANNELS-1:0];
      sw_d     <= in_s2[SW_BIT];
      hw_lvl_d <= hw_lvl;
      // Channel pulses feed the counters unmasked
      chan_pulse <= in_s2[NUM_CHANNELS-1:0] & ~chan_d;
      // A sw edge right behind a hw edge merges into the same trigger
      ph_trig <= (hw_edge | sw_edge) & ~ph_trig;
    end
  end

  // Downstream sees each trigger exactly once
  a_ph_trig_single: assert property (@(posedge axi_clk) disable iff (reset_hold_ET0)
    ph_trig |=> !ph_trig);

endmodule

`default_nettype wire
